/* addr_gen_top.f */
+incdir+source
source/addr_ctrl_pkg.sv
source/lane_table_pkg.sv
source/frame_counters.sv
source/rd_lane_bank.sv
source/wr_lane_bank.sv
source/addr_gen_top.sv
verif/addr_gen_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench, then look for the pass line in its output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f addr_gen_top.f --top-module addr_gen_tb -o addr_gen_sim &&
./obj_dir/addr_gen_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "run_sim: passed" ||
{
    echo "run_sim: failed"
    exit 1
}

/* verif/addr_gen_tb.sv */
`timescale 1ns/1ps

`include "addr_gen_defines.svh"

module addr_gen_tb;

    import addr_ctrl_pkg::*;
    import lane_table_pkg::*;

    localparam int VEC_W = `NUM_LANES * `ADDR_W;

    typedef logic [VEC_W-1:0] wide_t;

    logic           clk;
    logic           reset_n;
    phase_ctrl_t    ctrl;
    step_ctrl_t     step;
    lane_mask_t     sync_in;

    lane_addr_vec_t rd_lane_addr;
    lane_addr_vec_t wr_lane_addr;
    lane_mask_t     wr_lane_strobe;
    frame_addr_t    rd_frame_addr;
    frame_addr_t    wr_frame_addr;

    // reference state
    lane_addr_t     m_rd_base;
    lane_addr_t     m_wr_base;
    lane_addr_vec_t exp_rd_addr;
    lane_addr_vec_t exp_wr_addr;
    lane_mask_t     exp_strobe;
    frame_addr_t    exp_rd_frame;
    frame_addr_t    exp_wr_frame;

    int             seed;

    addr_gen_top UUT (
        .clk            (clk),
        .reset_n        (reset_n),
        .ctrl           (ctrl),
        .step           (step),
        .sync_in        (sync_in),
        .rd_lane_addr   (rd_lane_addr),
        .wr_lane_addr   (wr_lane_addr),
        .wr_lane_strobe (wr_lane_strobe),
        .rd_frame_addr  (rd_frame_addr),
        .wr_frame_addr  (wr_frame_addr)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input wide_t got, input wide_t exp);
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        stop_on_failure();
    endtask

    // base plus the offset byte that the phase picks, 8-bit wrap
    function automatic lane_addr_t expected_lane(
        input lane_addr_t base,
        input int         lane,
        input phase_t     phase
    );
        lane_offset_t offs;
        offs = lane_offset_table[lane];
        return base + offs[phase - 2'd1];
    endfunction

    // one past the current frame address, modulo FRAME_LAST + 1
    function automatic frame_addr_t frame_after(input frame_addr_t cur);
        return frame_addr_t'((cur + 1) % (`FRAME_LAST + 1));
    endfunction

    // ----------------------------------------
    // cycle model
    // ----------------------------------------

    always @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            m_rd_base    <= '0;
            m_wr_base    <= '0;
            exp_rd_addr  <= '0;
            exp_wr_addr  <= '0;
            exp_strobe   <= '0;
            exp_rd_frame <= '0;
            exp_wr_frame <= '0;
        end
        else
        begin
            if (!ctrl.run)
                m_rd_base <= '0;
            else if (step.rd_step)
                m_rd_base <= m_rd_base + lane_addr_t'(`BASE_STEP);
            if (!ctrl.run)
                m_wr_base <= '0;
            else if (step.wr_step)
                m_wr_base <= m_wr_base + lane_addr_t'(`BASE_STEP);
            if (step.rd_frame_step)
                exp_rd_frame <= frame_after(exp_rd_frame);
            if (step.wr_frame_step)
                exp_wr_frame <= frame_after(exp_wr_frame);
            for (int i = 0; i < `NUM_LANES; i++)
            begin
                if (ctrl.run && ctrl.rd_phase != 2'd0)
                    exp_rd_addr[i] <= expected_lane(m_rd_base, i, ctrl.rd_phase);
                if (ctrl.run && ctrl.wr_phase != 2'd0)
                    exp_wr_addr[i] <= expected_lane(m_wr_base, i, ctrl.wr_phase);
            end
            if (ctrl.run && ctrl.wr_phase != 2'd0)
                exp_strobe <= sync_in;
            else
                exp_strobe <= '0;
        end
    end

    // ----------------------------------------
    // checks, sampled mid-cycle
    // ----------------------------------------

    a_rd_addr: assert property (@(negedge clk) disable iff (!reset_n)
        rd_lane_addr == exp_rd_addr)
        else report_mismatch("rd_lane_addr", wide_t'(rd_lane_addr), wide_t'(exp_rd_addr));

    a_wr_addr: assert property (@(negedge clk) disable iff (!reset_n)
        wr_lane_addr == exp_wr_addr)
        else report_mismatch("wr_lane_addr", wide_t'(wr_lane_addr), wide_t'(exp_wr_addr));

    a_strobe: assert property (@(negedge clk) disable iff (!reset_n)
        wr_lane_strobe == exp_strobe)
        else report_mismatch("wr_lane_strobe", wide_t'(wr_lane_strobe), wide_t'(exp_strobe));

    a_rd_frame: assert property (@(negedge clk) disable iff (!reset_n)
        rd_frame_addr == exp_rd_frame)
        else report_mismatch("rd_frame_addr", wide_t'(rd_frame_addr), wide_t'(exp_rd_frame));

    a_wr_frame: assert property (@(negedge clk) disable iff (!reset_n)
        wr_frame_addr == exp_wr_frame)
        else report_mismatch("wr_frame_addr", wide_t'(wr_frame_addr), wide_t'(exp_wr_frame));

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    function automatic phase_ctrl_t make_ctrl(input logic run, input phase_t rdp, input phase_t wrp);
        phase_ctrl_t c;
        c.run      = run;
        c.rd_phase = rdp;
        c.wr_phase = wrp;
        return c;
    endfunction

    task automatic drive_cycle(input phase_ctrl_t c, input step_ctrl_t s, input lane_mask_t m);
        @(posedge clk);
        #2;
        ctrl    = c;
        step    = s;
        sync_in = m;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] r2;
        r  = $random(seed);
        r2 = $random(seed);
        // run is low about one cycle in eight
        drive_cycle(make_ctrl(r[2:0] != 3'd0, r[4:3], r[6:5]), r[10:7], {r[31:28], r2});
    endtask

    // a full count cycle of both frame strobes with run low, so each counter wraps once
    task automatic run_frames_to_wrap();
        repeat (`FRAME_LAST + 1)
            drive_cycle(make_ctrl(1'b0, 2'd0, 2'd0), 4'b0011, '0);
        drive_cycle(make_ctrl(1'b0, 2'd0, 2'd0), 4'b0000, '0);
    endtask

    initial
    begin
        seed    = 87;
        reset_n = 1'b0;
        ctrl    = '0;
        step    = '0;
        sync_in = '0;
        repeat (4) @(posedge clk);
        #2;
        reset_n = 1'b1;

        // idle with sync toggling, strobes must stay low
        drive_cycle(make_ctrl(1'b1, 2'd0, 2'd0), 4'b0000, '1);
        drive_cycle(make_ctrl(1'b0, 2'd0, 2'd0), 4'b0000, '1);

        // five base steps, then every phase on both sides
        repeat (5) drive_cycle(make_ctrl(1'b1, 2'd0, 2'd0), 4'b1100, '0);
        for (int p = 1; p <= 3; p++)
            drive_cycle(make_ctrl(1'b1, phase_t'(p), phase_t'(p)), 4'b0000, '1);
        drive_cycle(make_ctrl(1'b1, 2'd2, 2'd0), 4'b0000, '1);
        drive_cycle(make_ctrl(1'b1, 2'd0, 2'd0), 4'b0000, '1);

        // clear the bases, the next load gives bare offsets
        drive_cycle(make_ctrl(1'b0, 2'd0, 2'd0), 4'b1100, '0);
        drive_cycle(make_ctrl(1'b1, 2'd3, 2'd2), 4'b0000, 36'h5_a5a5_a5a5);
        drive_cycle(make_ctrl(1'b1, 2'd1, 2'd1), 4'b1100, '1);

        repeat (1500) drive_random();

        run_frames_to_wrap();
        repeat (3) drive_cycle(make_ctrl(1'b1, 2'd1, 2'd3), 4'b1111, '1);
        drive_cycle(make_ctrl(1'b0, 2'd0, 2'd0), 4'b0000, '0);
        @(posedge clk);
        repeat (2) @(negedge clk);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* source/addr_gen_top.sv */
`timescale 1ns/1ps

module addr_gen_top (
    input  logic                          clk,
    input  logic                          reset_n,
    input  addr_ctrl_pkg::phase_ctrl_t    ctrl,
    input  addr_ctrl_pkg::step_ctrl_t     step,
    input  addr_ctrl_pkg::lane_mask_t     sync_in,
    output addr_ctrl_pkg::lane_addr_vec_t rd_lane_addr,
    output addr_ctrl_pkg::lane_addr_vec_t wr_lane_addr,
    output addr_ctrl_pkg::lane_mask_t     wr_lane_strobe,
    output addr_ctrl_pkg::frame_addr_t    rd_frame_addr,
    output addr_ctrl_pkg::frame_addr_t    wr_frame_addr
);

    import addr_ctrl_pkg::*;

    lane_addr_t rd_base;
    lane_addr_t wr_base;

    // ----------------------------------------
    // shared counters
    // ----------------------------------------

    frame_counters u_counters (
        .clk           (clk),
        .reset_n       (reset_n),
        .ctrl          (ctrl),
        .step          (step),
        .rd_base       (rd_base),
        .wr_base       (wr_base),
        .rd_frame_addr (rd_frame_addr),
        .wr_frame_addr (wr_frame_addr)
    );

    // ----------------------------------------
    // lane address banks
    // ----------------------------------------

    // read side, one address per branch
    rd_lane_bank u_rd_bank (
        .clk       (clk),
        .reset_n   (reset_n),
        .ctrl      (ctrl),
        .base      (rd_base),
        .lane_addr (rd_lane_addr)
    );

    // write side, addresses plus sync-gated strobes
    wr_lane_bank u_wr_bank (
        .clk         (clk),
        .reset_n     (reset_n),
        .ctrl        (ctrl),
        .base        (wr_base),
        .sync        (sync_in),
        .lane_addr   (wr_lane_addr),
        .lane_strobe (wr_lane_strobe)
    );

endmodule

/* source/wr_lane_bank.sv */
`timescale 1ns/1ps

`include "addr_gen_defines.svh"

module wr_lane_bank (
    input  logic                          clk,
    input  logic                          reset_n,
    input  addr_ctrl_pkg::phase_ctrl_t    ctrl,
    input  addr_ctrl_pkg::lane_addr_t     base,
    input  addr_ctrl_pkg::lane_mask_t     sync,
    output addr_ctrl_pkg::lane_addr_vec_t lane_addr,
    output addr_ctrl_pkg::lane_mask_t     lane_strobe
);

    import addr_ctrl_pkg::*;
    import lane_table_pkg::*;

    logic           active;
    wire  lane_addr_vec_t next_addr;

    assign active = ctrl.run && (ctrl.wr_phase != PHASE_IDLE);

    genvar i;
    generate
        for (i = 0; i < `NUM_LANES; i++)
        begin : g_lane
            assign next_addr[i] = lane_address(base, lane_offset_table[i], ctrl.wr_phase);
        end
    endgenerate

    // ----------------------------------------
    // write addresses
    // ----------------------------------------

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            lane_addr <= '0;
        else if (active)
            lane_addr <= next_addr;
    end

    // ----------------------------------------
    // RAM write strobes
    // ----------------------------------------

    // one cycle wide, dropped whenever the write side is idle
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            lane_strobe <= '0;
        else if (active)
            lane_strobe <= sync;
        else
            lane_strobe <= '0;
    end

endmodule

/* source/rd_lane_bank.sv */
`timescale 1ns/1ps

`include "addr_gen_defines.svh"

module rd_lane_bank (
    input  logic                          clk,
    input  logic                          reset_n,
    input  addr_ctrl_pkg::phase_ctrl_t    ctrl,
    input  addr_ctrl_pkg::lane_addr_t     base,
    output addr_ctrl_pkg::lane_addr_vec_t lane_addr
);

    import addr_ctrl_pkg::*;
    import lane_table_pkg::*;

    logic           active;
    wire  lane_addr_vec_t next_addr;

    assign active = ctrl.run && (ctrl.rd_phase != PHASE_IDLE);

    // per-lane address from the shared base
    genvar i;
    generate
        for (i = 0; i < `NUM_LANES; i++)
        begin : g_lane
            assign next_addr[i] = lane_address(base, lane_offset_table[i], ctrl.rd_phase);
        end
    endgenerate

    // hold on idle phases
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            lane_addr <= '0;
        else if (active)
            lane_addr <= next_addr;
    end

endmodule

/* source/frame_counters.sv */
`timescale 1ns/1ps

`include "addr_gen_defines.svh"

module frame_counters (
    input  logic                       clk,
    input  logic                       reset_n,
    input  addr_ctrl_pkg::phase_ctrl_t ctrl,
    input  addr_ctrl_pkg::step_ctrl_t  step,
    output addr_ctrl_pkg::lane_addr_t  rd_base,
    output addr_ctrl_pkg::lane_addr_t  wr_base,
    output addr_ctrl_pkg::frame_addr_t rd_frame_addr,
    output addr_ctrl_pkg::frame_addr_t wr_frame_addr
);

    import addr_ctrl_pkg::*;

    function automatic lane_addr_t next_base(input lane_addr_t cur);
        return lane_addr_t'(cur + `BASE_STEP);
    endfunction

    function automatic frame_addr_t next_frame(input frame_addr_t cur);
        if (cur == frame_addr_t'(`FRAME_LAST))
            return '0;
        return cur + 1'b1;
    endfunction

    // ----------------------------------------
    // base counters, held at zero while idle
    // ----------------------------------------

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            rd_base <= '0;
        else if (!ctrl.run)
            rd_base <= '0;
        else if (step.rd_step)
            rd_base <= next_base(rd_base);
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            wr_base <= '0;
        else if (!ctrl.run)
            wr_base <= '0;
        else if (step.wr_step)
            wr_base <= next_base(wr_base);
    end

    // ----------------------------------------
    // linear frame counters
    // ----------------------------------------

    // free of run, only the frame strobes move them
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            rd_frame_addr <= '0;
        else if (step.rd_frame_step)
            rd_frame_addr <= next_frame(rd_frame_addr);
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            wr_frame_addr <= '0;
        else if (step.wr_frame_step)
            wr_frame_addr <= next_frame(wr_frame_addr);
    end

endmodule

/* source/lane_table_pkg.sv */
`include "addr_gen_defines.svh"

package lane_table_pkg;

    import addr_ctrl_pkg::*;

    // byte 0 in the low bits
    typedef lane_addr_t [`NUM_PHASES-1:0] lane_offset_t;

    // per-lane offsets, written as {byte 2, byte 1, byte 0}
    localparam lane_offset_t lane_offset_table [`NUM_LANES] = '{
        {8'd0,   8'd0,   8'd0},
        {8'd0,   8'd0,   8'd0},
        {8'd0,   8'd0,   8'd0},
        {8'd0,   8'd0,   8'd0},
        {8'd0,   8'd0,   8'd0},
        {8'd0,   8'd0,   8'd0},
        {8'd0,   8'd0,   8'd0},
        {8'd0,   8'd0,   8'd0},
        {8'd0,   8'd255, 8'd0},
        {8'd0,   8'd129, 8'd65},
        {8'd0,   8'd224, 8'd240},
        {8'd0,   8'd216, 8'd236},
        {8'd0,   8'd157, 8'd250},
        {8'd0,   8'd132, 8'd242},
        {8'd0,   8'd184, 8'd247},
        {8'd0,   8'd254, 8'd240},
        {8'd0,   8'd115, 8'd242},
        {8'd0,   8'd209, 8'd164},
        {8'd0,   8'd255, 8'd248},
        {8'd0,   8'd246, 8'd58},
        {8'd0,   8'd253, 8'd215},
        {8'd0,   8'd252, 8'd209},
        {8'd0,   8'd146, 8'd249},
        {8'd0,   8'd231, 8'd250},
        {8'd254, 8'd200, 8'd0},
        {8'd0,   8'd85,  8'd235},
        {8'd0,   8'd229, 8'd69},
        {8'd0,   8'd203, 8'd254},
        {8'd0,   8'd131, 8'd251},
        {8'd0,   8'd115, 8'd254},
        {8'd0,   8'd253, 8'd255},
        {8'd0,   8'd248, 8'd254},
        {8'd0,   8'd255, 8'd243},
        {8'd0,   8'd239, 8'd253},
        {8'd0,   8'd248, 8'd215},
        {8'd0,   8'd252, 8'd164}
    };

    // base plus the phase-selected offset byte, wrapping at 256
    function automatic lane_addr_t lane_address(
        input lane_addr_t   base,
        input lane_offset_t offset,
        input phase_t       phase
    );
        lane_addr_t sel;
        case (phase)
            2'd1:    sel = offset[0];
            2'd2:    sel = offset[1];
            2'd3:    sel = offset[2];
            default: sel = '0;
        endcase
        return lane_addr_t'(base + sel);
    endfunction

endpackage

/* source/addr_ctrl_pkg.sv */
`include "addr_gen_defines.svh"

package addr_ctrl_pkg;

    typedef logic [`ADDR_W-1:0]  lane_addr_t;
    typedef logic [`FRAME_W-1:0] frame_addr_t;

    // 0 is idle, 1..3 pick offset byte 0..2
    typedef logic [1:0] phase_t;

    localparam phase_t PHASE_IDLE = 2'd0;

    typedef struct packed {
        logic   run;
        phase_t rd_phase;
        phase_t wr_phase;
    } phase_ctrl_t;

    // single-cycle strobes
    typedef struct packed {
        logic rd_step;
        logic wr_step;
        logic rd_frame_step;
        logic wr_frame_step;
    } step_ctrl_t;

    typedef lane_addr_t [`NUM_LANES-1:0] lane_addr_vec_t;

    typedef logic [`NUM_LANES-1:0] lane_mask_t;

endpackage

/* source/addr_gen_defines.svh */
`ifndef ADDR_GEN_DEFINES_SVH
`define ADDR_GEN_DEFINES_SVH

// address and counter widths
`define ADDR_W      8
`define FRAME_W     10

// interleaver geometry
`define NUM_LANES   36
`define NUM_PHASES  3

// base counter increment, modulo 2**ADDR_W
`define BASE_STEP   37

// linear frame counters wrap after this value
`define FRAME_LAST  767

`endif
